// ==== rtl/tdes_pkg.sv ====
package tdes_pkg;

	////////////////////////////////////////
	// Data path widths
	////////////////////////////////////////

	localparam int HALF_W  = 64;
	localparam int BLOCK_W = 2 * HALF_W;
	localparam int LANE_W  = 16;

	typedef logic [HALF_W-1:0]  half_t;
	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [HALF_W-1:0]  key_t;
	typedef logic [LANE_W-1:0]  lane_t;

	////////////////////////////////////////
	// Round constants
	////////////////////////////////////////

	localparam int ROUNDS_PER_STAGE = 16;
	localparam int NUM_STAGES       = 3;

	// Rounds over all three stages
	localparam int TOTAL_ROUNDS = NUM_STAGES * ROUNDS_PER_STAGE;

endpackage

// ==== rtl/tdes_ctrl_pkg.sv ====
package tdes_ctrl_pkg;

	// Top level sequencing
	typedef enum logic [1:0] {
		SEQ_LOAD,
		SEQ_RUN,
		SEQ_FINISH,
		SEQ_HOLD
	} seq_state_t;

	// Stage order is DEC3, ENC2, DEC1
	typedef enum logic [1:0] {
		STAGE_DEC3,
		STAGE_ENC2,
		STAGE_DEC1
	} stage_t;

	typedef logic [$clog2(tdes_pkg::ROUNDS_PER_STAGE)-1:0] round_t;

endpackage

// ==== rtl/tdes_sequencer.sv ====
`timescale 1ns/1ps

module tdes_sequencer (
	input  logic                  clk,
	input  logic                  rst,
	output logic                  load,
	output logic                  run,
	output logic                  last_round,
	output logic                  finish,
	output tdes_ctrl_pkg::stage_t stage
);

	tdes_ctrl_pkg::seq_state_t state;
	tdes_ctrl_pkg::round_t     cnt;

	localparam tdes_ctrl_pkg::round_t LAST_CNT =
		tdes_ctrl_pkg::round_t'(tdes_pkg::ROUNDS_PER_STAGE - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= tdes_ctrl_pkg::SEQ_LOAD;
			cnt   <= '0;
			stage <= tdes_ctrl_pkg::STAGE_DEC3;
		end else begin
			case (state)
				tdes_ctrl_pkg::SEQ_LOAD: begin
					state <= tdes_ctrl_pkg::SEQ_RUN;
					cnt   <= '0;
					stage <= tdes_ctrl_pkg::STAGE_DEC3;
				end
				tdes_ctrl_pkg::SEQ_RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == LAST_CNT) begin
						case (stage)
							tdes_ctrl_pkg::STAGE_DEC3: stage <= tdes_ctrl_pkg::STAGE_ENC2;
							tdes_ctrl_pkg::STAGE_ENC2: stage <= tdes_ctrl_pkg::STAGE_DEC1;
							default: state <= tdes_ctrl_pkg::SEQ_FINISH;
						endcase
					end
				end
				tdes_ctrl_pkg::SEQ_FINISH: begin
					state <= tdes_ctrl_pkg::SEQ_HOLD;
				end
				default: begin
					// Stays here until the next reset
					state <= tdes_ctrl_pkg::SEQ_HOLD;
				end
			endcase
		end
	end

	// Load only in the first cycle with rst low
	assign load       = !rst && (state == tdes_ctrl_pkg::SEQ_LOAD);
	assign run        = (state == tdes_ctrl_pkg::SEQ_RUN);
	assign last_round = run && (cnt == LAST_CNT);
	assign finish     = (state == tdes_ctrl_pkg::SEQ_FINISH);

	////////////////////////////////////////
	// Assertions
	////////////////////////////////////////

	a_load_then_run: assert property (@(posedge clk) disable iff (rst)
		load |=> run && !load);

	// Finish arrives one edge after the last of all rounds
	a_finish_time: assert property (@(posedge clk) disable iff (rst)
		load |-> ##(tdes_pkg::TOTAL_ROUNDS + 1) finish);

	a_finish_once: assert property (@(posedge clk) disable iff (rst)
		finish |=> !finish && state == tdes_ctrl_pkg::SEQ_HOLD);

endmodule

// ==== rtl/tdes_key_schedule.sv ====
`timescale 1ns/1ps

module tdes_key_schedule (
	input  logic                  clk,
	input  logic                  load,
	input  logic                  run,
	input  logic                  last_round,
	input  tdes_ctrl_pkg::stage_t stage,
	input  tdes_pkg::key_t        ek1,
	input  tdes_pkg::key_t        ek2,
	input  tdes_pkg::key_t        ek3,
	output tdes_pkg::key_t        round_key
);

	// One step of the lane mixing, a3 is the top lane
	function automatic tdes_pkg::key_t step_key(input tdes_pkg::key_t a);
		tdes_pkg::lane_t a0;
		tdes_pkg::lane_t a1;
		tdes_pkg::lane_t a2;
		tdes_pkg::lane_t a3;
		a0 = a[0*tdes_pkg::LANE_W +: tdes_pkg::LANE_W];
		a1 = a[1*tdes_pkg::LANE_W +: tdes_pkg::LANE_W];
		a2 = a[2*tdes_pkg::LANE_W +: tdes_pkg::LANE_W];
		a3 = a[3*tdes_pkg::LANE_W +: tdes_pkg::LANE_W];
		return {a1 ^ a0 ^ a3, a2 ^ a3, a1 ^ a2, a1 ^ a0};
	endfunction

	always_ff @(posedge clk) begin
		if (load) begin
			round_key <= ek3;
		end else if (run) begin
			if (last_round) begin
				// Next stage starts from its own key
				case (stage)
					tdes_ctrl_pkg::STAGE_DEC3: round_key <= ek2;
					tdes_ctrl_pkg::STAGE_ENC2: round_key <= ek1;
					default: round_key <= round_key;
				endcase
			end else begin
				round_key <= step_key(round_key);
			end
		end
	end

	// No reload or step after the final stage
	a_no_reload_after_dec1: assert property (@(posedge clk)
		(last_round && stage == tdes_ctrl_pkg::STAGE_DEC1) |-> run ##1 !run);

endmodule

// ==== rtl/tdes_feistel_round.sv ====
`timescale 1ns/1ps

module tdes_feistel_round (
	input  logic                  clk,
	input  logic                  load,
	input  logic                  run,
	input  tdes_ctrl_pkg::stage_t stage,
	input  tdes_pkg::block_t      ct,
	input  tdes_pkg::key_t        round_key,
	output tdes_pkg::block_t      block
);

	tdes_pkg::half_t l;
	tdes_pkg::half_t r;
	tdes_pkg::half_t l_next;
	tdes_pkg::half_t r_next;

	always_comb begin
		if (stage == tdes_ctrl_pkg::STAGE_ENC2) begin
			// Encrypt round
			l_next = r;
			r_next = l ^ r ^ round_key;
		end else begin
			// Decrypt round
			l_next = r ^ round_key ^ l;
			r_next = l;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			l <= ct[tdes_pkg::BLOCK_W-1 -: tdes_pkg::HALF_W];
			r <= ct[tdes_pkg::HALF_W-1:0];
		end else if (run) begin
			l <= l_next;
			r <= r_next;
		end
	end

	// Left half in the upper bits
	assign block = {l, r};

endmodule

// ==== rtl/tdes_result_capture.sv ====
`timescale 1ns/1ps

module tdes_result_capture (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  last_round,
	input  logic                  finish,
	input  tdes_ctrl_pkg::stage_t stage,
	input  tdes_pkg::key_t        round_key,
	input  tdes_pkg::block_t      block,
	output tdes_pkg::block_t      pt,
	output tdes_pkg::key_t        k1,
	output tdes_pkg::key_t        k2,
	output tdes_pkg::key_t        k3
);

	always_ff @(posedge clk) begin
		if (rst) begin
			pt <= '0;
			k1 <= '0;
			k2 <= '0;
			k3 <= '0;
		end else begin
			// Key of round 15 in each stage
			if (last_round) begin
				case (stage)
					tdes_ctrl_pkg::STAGE_DEC3: k3 <= round_key;
					tdes_ctrl_pkg::STAGE_ENC2: k2 <= round_key;
					default: k1 <= round_key;
				endcase
			end
			if (finish) begin
				pt <= block;
			end
		end
	end

	// Finish follows the last DEC1 round on the next edge, never with it
	a_finish_after_last: assert property (@(posedge clk) disable iff (rst)
		(last_round && stage == tdes_ctrl_pkg::STAGE_DEC1) |=> finish && !last_round);

endmodule

// ==== rtl/tdes_dec.sv ====
`timescale 1ns/1ps

module tdes_dec (
	input  logic             clk,
	input  logic             rst,
	input  tdes_pkg::key_t   ek1,
	input  tdes_pkg::key_t   ek2,
	input  tdes_pkg::key_t   ek3,
	input  tdes_pkg::block_t ct,
	output tdes_pkg::block_t pt,
	output tdes_pkg::key_t   k1,
	output tdes_pkg::key_t   k2,
	output tdes_pkg::key_t   k3
);

	logic                  load;
	logic                  run;
	logic                  last_round;
	logic                  finish;
	tdes_ctrl_pkg::stage_t stage;
	tdes_pkg::key_t        round_key;
	tdes_pkg::block_t      block;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	tdes_sequencer seq0 (
		.clk        (clk),
		.rst        (rst),
		.load       (load),
		.run        (run),
		.last_round (last_round),
		.finish     (finish),
		.stage      (stage)
	);

	////////////////////////////////////////
	// Data path
	////////////////////////////////////////

	tdes_key_schedule keys0 (
		.clk        (clk),
		.load       (load),
		.run        (run),
		.last_round (last_round),
		.stage      (stage),
		.ek1        (ek1),
		.ek2        (ek2),
		.ek3        (ek3),
		.round_key  (round_key)
	);

	tdes_feistel_round round0 (
		.clk        (clk),
		.load       (load),
		.run        (run),
		.stage      (stage),
		.ct         (ct),
		.round_key  (round_key),
		.block      (block)
	);

	// Output registers
	tdes_result_capture cap0 (
		.clk        (clk),
		.rst        (rst),
		.last_round (last_round),
		.finish     (finish),
		.stage      (stage),
		.round_key  (round_key),
		.block      (block),
		.pt         (pt),
		.k1         (k1),
		.k2         (k2),
		.k3         (k3)
	);

endmodule

// ==== tb/tb_tdes_dec.sv ====
`timescale 1ns/1ps

module tb_tdes_dec;

	localparam int WAIT_LIMIT = 200;
	localparam int NUM_RANDOM = 20;

	logic             clk = 1'b0;
	logic             rst = 1'b1;
	tdes_pkg::key_t   ek1 = '0;
	tdes_pkg::key_t   ek2 = '0;
	tdes_pkg::key_t   ek3 = '0;
	tdes_pkg::block_t ct  = '0;
	tdes_pkg::block_t pt;
	tdes_pkg::key_t   k1;
	tdes_pkg::key_t   k2;
	tdes_pkg::key_t   k3;

	logic [31:0]      lfsr = 32'hb138_ce85;
	int               edge_no = 0;
	int               rst_edges = 0;
	int               pt_checks = 0;
	string            test_name = "init";
	string            cur_name = "init";
	tdes_pkg::block_t exp_pt = '0;
	tdes_pkg::key_t   exp_k1 = '0;
	tdes_pkg::key_t   exp_k2 = '0;
	tdes_pkg::key_t   exp_k3 = '0;

	tdes_dec dut0 (
		.clk (clk),
		.rst (rst),
		.ek1 (ek1),
		.ek2 (ek2),
		.ek3 (ek3),
		.ct  (ct),
		.pt  (pt),
		.k1  (k1),
		.k2  (k2),
		.k3  (k3)
	);

	always #10 clk = ~clk;

	// Edges since rst fell, and edges seen in the current reset
	always @(posedge clk) begin
		cur_name <= test_name;
		if (rst) begin
			edge_no   <= 0;
			rst_edges <= rst_edges + 1;
		end else begin
			edge_no   <= edge_no + 1;
			rst_edges <= 0;
		end
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic tdes_pkg::key_t key_step(input tdes_pkg::key_t a);
		tdes_pkg::key_t res;
		res[15:0]  = a[31:16] ^ a[15:0];
		res[31:16] = a[31:16] ^ a[47:32];
		res[47:32] = a[47:32] ^ a[63:48];
		res[63:48] = a[31:16] ^ a[15:0] ^ a[63:48];
		return res;
	endfunction

	function automatic tdes_pkg::key_t key_step_n(input tdes_pkg::key_t a, input int n);
		tdes_pkg::key_t k;
		k = a;
		for (int i = 0; i < n; i++) begin
			k = key_step(k);
		end
		return k;
	endfunction

	function automatic tdes_pkg::block_t tdes_ref(input tdes_pkg::block_t c,
			input tdes_pkg::key_t e1, input tdes_pkg::key_t e2, input tdes_pkg::key_t e3);
		tdes_pkg::half_t l;
		tdes_pkg::half_t r;
		tdes_pkg::half_t t;
		tdes_pkg::key_t  k;
		l = c[127:64];
		r = c[63:0];
		for (int s = 0; s < tdes_pkg::NUM_STAGES; s++) begin
			case (s)
				0: k = e3;
				1: k = e2;
				default: k = e1;
			endcase
			for (int n = 0; n < tdes_pkg::ROUNDS_PER_STAGE; n++) begin
				if (s == 1) begin
					// Middle stage encrypts
					t = l ^ r ^ k;
					l = r;
					r = t;
				end else begin
					t = r ^ k ^ l;
					r = l;
					l = t;
				end
				k = key_step(k);
			end
		end
		return {l, r};
	endfunction

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output tdes_pkg::block_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[126:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input tdes_pkg::block_t expected,
			input tdes_pkg::block_t actual);
		if (actual !== expected) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			$display("Errors found");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic wait_run_edge(input int target);
		int waited;
		waited = 0;
		while (edge_no < target) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("Timed out waiting for run edge %0d", target);
				$display("Errors found");
				$fatal(1, "timeout");
			end
		end
	endtask

	task automatic wait_reset_edges(input int count);
		int waited;
		waited = 0;
		while (rst_edges < count) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("Timed out waiting for %0d reset edges", count);
				$display("Errors found");
				$fatal(1, "timeout");
			end
		end
	endtask

	// Called on a falling edge; abort stops the run before edge 25
	task automatic run_vector(input string name, input tdes_pkg::block_t c,
			input tdes_pkg::key_t e1, input tdes_pkg::key_t e2, input tdes_pkg::key_t e3,
			input logic abort);
		tdes_pkg::block_t junk;
		rst       = 1'b1;
		test_name = name;
		ct        = c;
		ek1       = e1;
		ek2       = e2;
		ek3       = e3;
		wait_reset_edges(1);
		exp_pt = tdes_ref(c, e1, e2, e3);
		exp_k1 = key_step_n(e1, tdes_pkg::ROUNDS_PER_STAGE - 1);
		exp_k2 = key_step_n(e2, tdes_pkg::ROUNDS_PER_STAGE - 1);
		exp_k3 = key_step_n(e3, tdes_pkg::ROUNDS_PER_STAGE - 1);
		wait_reset_edges(4);
		rst = 1'b0;
		if (abort) begin
			wait_run_edge(24);
		end else begin
			wait_run_edge(50);
			// New inputs must not disturb the held result
			draw_bits(128, junk);
			ct = junk;
			draw_bits(64, junk);
			ek1 = junk[63:0];
			draw_bits(64, junk);
			ek2 = junk[63:0];
			draw_bits(64, junk);
			ek3 = junk[63:0];
			wait_run_edge(80);
		end
	endtask

	////////////////////////////////////////
	// Checker
	////////////////////////////////////////

	always @(negedge clk) begin
		if (rst_edges > 0 || edge_no == 1) begin
			check_value($sformatf("%s zero pt", cur_name), '0, pt);
			check_value($sformatf("%s zero k1", cur_name), '0, {64'h0, k1});
			check_value($sformatf("%s zero k2", cur_name), '0, {64'h0, k2});
			check_value($sformatf("%s zero k3", cur_name), '0, {64'h0, k3});
		end else if (edge_no == 17) begin
			check_value($sformatf("%s k3", cur_name), {64'h0, exp_k3}, {64'h0, k3});
		end else if (edge_no == 33) begin
			check_value($sformatf("%s k2", cur_name), {64'h0, exp_k2}, {64'h0, k2});
		end else if (edge_no == 49) begin
			check_value($sformatf("%s k1", cur_name), {64'h0, exp_k1}, {64'h0, k1});
		end else if (edge_no >= 50) begin
			check_value($sformatf("%s pt", cur_name), exp_pt, pt);
			check_value($sformatf("%s held k1", cur_name), {64'h0, exp_k1}, {64'h0, k1});
			check_value($sformatf("%s held k2", cur_name), {64'h0, exp_k2}, {64'h0, k2});
			check_value($sformatf("%s held k3", cur_name), {64'h0, exp_k3}, {64'h0, k3});
			if (edge_no == 50) begin
				pt_checks <= pt_checks + 1;
			end
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		tdes_pkg::block_t c;
		tdes_pkg::block_t t;
		tdes_pkg::key_t   e1;
		tdes_pkg::key_t   e2;
		tdes_pkg::key_t   e3;
		run_vector("zero", '0, '0, '0, '0, 1'b0);
		for (int i = 0; i < NUM_RANDOM + 2; i++) begin
			draw_bits(128, c);
			draw_bits(64, t);
			e1 = t[63:0];
			draw_bits(64, t);
			e2 = t[63:0];
			draw_bits(64, t);
			e3 = t[63:0];
			if (i < NUM_RANDOM) begin
				run_vector($sformatf("random %0d", i), c, e1, e2, e3, 1'b0);
			end else if (i == NUM_RANDOM) begin
				run_vector("aborted run", c, e1, e2, e3, 1'b1);
			end else begin
				run_vector("after abort", c, e1, e2, e3, 1'b0);
			end
		end
		if (pt_checks != NUM_RANDOM + 2) begin
			$display("Only %0d of %0d results were checked", pt_checks, NUM_RANDOM + 2);
			$display("Errors found");
			$fatal(1, "missing result checks");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

// ==== flist.f ====
rtl/tdes_pkg.sv
rtl/tdes_ctrl_pkg.sv
rtl/tdes_sequencer.sv
rtl/tdes_key_schedule.sv
rtl/tdes_feistel_round.sv
rtl/tdes_result_capture.sv
rtl/tdes_dec.sv
tb/tb_tdes_dec.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_tdes_dec -o sim_tdes \
	&& ./obj_dir/sim_tdes \
	|| exit 1
